/* verilog/cpu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types and constants of the 8-bit accumulator core
// every unit refers to these through cpu_pkg:: scoped names
//////////////////////////////////////////////////////////////////////

package cpu_pkg;

  localparam logic [15:0] reset_pc = 16'h0400;
  localparam logic [7:0] zero_page_hi = 8'h00;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_operand,
    st_addr_hi,
    st_mem_read,
    st_mem_write,
    st_execute
  } cpu_state_e;

  // 6502 encodings of the kept instructions
  typedef enum logic [7:0] {
    op_lda_imm = 8'hA9,
    op_lda_zp  = 8'hA5,
    op_ldx_imm = 8'hA2,
    op_ldx_zp  = 8'hA6,
    op_ldy_imm = 8'hA0,
    op_ldy_zp  = 8'hA4,
    op_sta_zp  = 8'h85,
    op_stx_zp  = 8'h86,
    op_sty_zp  = 8'h84,
    op_ora_imm = 8'h09,
    op_ora_zp  = 8'h05,
    op_and_imm = 8'h29,
    op_and_zp  = 8'h25,
    op_eor_imm = 8'h49,
    op_eor_zp  = 8'h45,
    op_adc_imm = 8'h69,
    op_adc_zp  = 8'h65,
    op_sbc_imm = 8'hE9,
    op_sbc_zp  = 8'hE5,
    op_cmp_imm = 8'hC9,
    op_cmp_zp  = 8'hC5,
    op_tax     = 8'hAA,
    op_txa     = 8'h8A,
    op_tay     = 8'hA8,
    op_tya     = 8'h98,
    op_inx     = 8'hE8,
    op_iny     = 8'hC8,
    op_dex     = 8'hCA,
    op_dey     = 8'h88,
    op_clc     = 8'h18,
    op_sec     = 8'h38,
    op_jmp_abs = 8'h4C,
    op_nop     = 8'hEA
  } opcode_e;

  typedef enum logic [2:0] {alu_or, alu_and, alu_eor, alu_add, alu_sub, alu_pass_a} alu_op_e;
  typedef enum logic [1:0] {reg_a, reg_x, reg_y, reg_none} reg_sel_e;
  typedef enum logic [1:0] {am_implied, am_immediate, am_zero_page, am_absolute} amode_e;
  typedef enum logic [1:0] {cin_zero, cin_one, cin_flag} cin_sel_e;

  typedef struct packed {
    amode_e amode;
    alu_op_e op;
    reg_sel_e src;
    reg_sel_e dst;
    cin_sel_e cin;
    logic writes_mem;
    logic sets_nz;
    logic sets_cv;
    logic set_carry;
    logic clear_carry;
    logic is_jump;
  } decoded_t;

  // what every unknown byte turns into
  localparam decoded_t dec_nop = '{
    amode: am_implied,
    op: alu_pass_a,
    src: reg_none,
    dst: reg_none,
    cin: cin_zero,
    writes_mem: 1'b0,
    sets_nz: 1'b0,
    sets_cv: 1'b0,
    set_carry: 1'b0,
    clear_carry: 1'b0,
    is_jump: 1'b0
  };

  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } p_flags_t;

  typedef struct packed {
    logic [7:0] value;
    logic carry;
    logic overflow;
  } alu_result_t;

  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [15:0] adr;
    logic [7:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic ack;
    logic [7:0] dat;
  } wb_s2m_t;

endpackage

/* verilog/op_decoder.sv */
//////////////////////////////////////////////////////////////////////
// opcode decode, purely combinational
// fed by the sequencer's opcode byte, result steers sequencer and regs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module op_decoder (
  input logic [7:0] opcode,
  output cpu_pkg::decoded_t dec
);

  // accumulator style row, always updates n and z
  function automatic cpu_pkg::decoded_t alu_row(
    input cpu_pkg::alu_op_e op,
    input cpu_pkg::reg_sel_e src,
    input cpu_pkg::reg_sel_e dst,
    input cpu_pkg::cin_sel_e cin,
    input logic sets_cv
  );
    cpu_pkg::decoded_t d;
    d = cpu_pkg::dec_nop;
    d.op = op;
    d.src = src;
    d.dst = dst;
    d.cin = cin;
    d.sets_nz = 1'b1;
    d.sets_cv = sets_cv;
    return d;
  endfunction

  always_comb begin
    dec = cpu_pkg::dec_nop;
    case (cpu_pkg::opcode_e'(opcode))
      // loads pass b through an add with a = 0
      cpu_pkg::op_lda_imm, cpu_pkg::op_lda_zp:
        dec = alu_row(cpu_pkg::alu_add, cpu_pkg::reg_none, cpu_pkg::reg_a,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_ldx_imm, cpu_pkg::op_ldx_zp:
        dec = alu_row(cpu_pkg::alu_add, cpu_pkg::reg_none, cpu_pkg::reg_x,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_ldy_imm, cpu_pkg::op_ldy_zp:
        dec = alu_row(cpu_pkg::alu_add, cpu_pkg::reg_none, cpu_pkg::reg_y,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_ora_imm, cpu_pkg::op_ora_zp:
        dec = alu_row(cpu_pkg::alu_or, cpu_pkg::reg_a, cpu_pkg::reg_a,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_and_imm, cpu_pkg::op_and_zp:
        dec = alu_row(cpu_pkg::alu_and, cpu_pkg::reg_a, cpu_pkg::reg_a,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_eor_imm, cpu_pkg::op_eor_zp:
        dec = alu_row(cpu_pkg::alu_eor, cpu_pkg::reg_a, cpu_pkg::reg_a,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_adc_imm, cpu_pkg::op_adc_zp:
        dec = alu_row(cpu_pkg::alu_add, cpu_pkg::reg_a, cpu_pkg::reg_a,
                      cpu_pkg::cin_flag, 1'b1);
      cpu_pkg::op_sbc_imm, cpu_pkg::op_sbc_zp:
        dec = alu_row(cpu_pkg::alu_sub, cpu_pkg::reg_a, cpu_pkg::reg_a,
                      cpu_pkg::cin_flag, 1'b1);
      // compare is a subtract that keeps A
      cpu_pkg::op_cmp_imm, cpu_pkg::op_cmp_zp:
        dec = alu_row(cpu_pkg::alu_sub, cpu_pkg::reg_a, cpu_pkg::reg_none,
                      cpu_pkg::cin_one, 1'b1);
      cpu_pkg::op_tax:
        dec = alu_row(cpu_pkg::alu_pass_a, cpu_pkg::reg_a, cpu_pkg::reg_x,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_txa:
        dec = alu_row(cpu_pkg::alu_pass_a, cpu_pkg::reg_x, cpu_pkg::reg_a,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_tay:
        dec = alu_row(cpu_pkg::alu_pass_a, cpu_pkg::reg_a, cpu_pkg::reg_y,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_tya:
        dec = alu_row(cpu_pkg::alu_pass_a, cpu_pkg::reg_y, cpu_pkg::reg_a,
                      cpu_pkg::cin_zero, 1'b0);
      // b is 0 here, so +1 via carry in and -1 via ~0
      cpu_pkg::op_inx:
        dec = alu_row(cpu_pkg::alu_add, cpu_pkg::reg_x, cpu_pkg::reg_x,
                      cpu_pkg::cin_one, 1'b0);
      cpu_pkg::op_iny:
        dec = alu_row(cpu_pkg::alu_add, cpu_pkg::reg_y, cpu_pkg::reg_y,
                      cpu_pkg::cin_one, 1'b0);
      cpu_pkg::op_dex:
        dec = alu_row(cpu_pkg::alu_sub, cpu_pkg::reg_x, cpu_pkg::reg_x,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_dey:
        dec = alu_row(cpu_pkg::alu_sub, cpu_pkg::reg_y, cpu_pkg::reg_y,
                      cpu_pkg::cin_zero, 1'b0);
      cpu_pkg::op_sta_zp: begin
        dec.src = cpu_pkg::reg_a;
        dec.writes_mem = 1'b1;
      end
      cpu_pkg::op_stx_zp: begin
        dec.src = cpu_pkg::reg_x;
        dec.writes_mem = 1'b1;
      end
      cpu_pkg::op_sty_zp: begin
        dec.src = cpu_pkg::reg_y;
        dec.writes_mem = 1'b1;
      end
      cpu_pkg::op_clc: dec.clear_carry = 1'b1;
      cpu_pkg::op_sec: dec.set_carry = 1'b1;
      cpu_pkg::op_jmp_abs: dec.is_jump = 1'b1;
      cpu_pkg::op_nop: dec = cpu_pkg::dec_nop;
      default: dec = cpu_pkg::dec_nop;
    endcase

    case (cpu_pkg::opcode_e'(opcode))
      cpu_pkg::op_lda_imm, cpu_pkg::op_ldx_imm, cpu_pkg::op_ldy_imm,
      cpu_pkg::op_ora_imm, cpu_pkg::op_and_imm, cpu_pkg::op_eor_imm,
      cpu_pkg::op_adc_imm, cpu_pkg::op_sbc_imm, cpu_pkg::op_cmp_imm:
        dec.amode = cpu_pkg::am_immediate;
      cpu_pkg::op_lda_zp, cpu_pkg::op_ldx_zp, cpu_pkg::op_ldy_zp,
      cpu_pkg::op_ora_zp, cpu_pkg::op_and_zp, cpu_pkg::op_eor_zp,
      cpu_pkg::op_adc_zp, cpu_pkg::op_sbc_zp, cpu_pkg::op_cmp_zp,
      cpu_pkg::op_sta_zp, cpu_pkg::op_stx_zp, cpu_pkg::op_sty_zp:
        dec.amode = cpu_pkg::am_zero_page;
      cpu_pkg::op_jmp_abs: dec.amode = cpu_pkg::am_absolute;
      default: dec.amode = cpu_pkg::am_implied;
    endcase

    // sequencer leaves the operand state by exactly one of these paths
    assert (!(dec.writes_mem && dec.is_jump))
      else $error("decoder: store and jump both set for opcode %h", opcode);
  end

endmodule

/* verilog/alu8.sv */
//////////////////////////////////////////////////////////////////////
// 8-bit ALU, logic ops plus add and subtract with carry in
// overflow follows the 6502 rule on the signed result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu8 (
  input cpu_pkg::alu_op_e op,
  input logic [7:0] a,
  input logic [7:0] b,
  input logic cin,
  output cpu_pkg::alu_result_t res
);

  logic [7:0] b_eff;
  logic [8:0] sum;

  always_comb begin
    // subtract is a + ~b + cin
    b_eff = (op == cpu_pkg::alu_sub) ? ~b : b;
    sum = {1'b0, a} + {1'b0, b_eff} + {8'h00, cin};
    res.carry = 1'b0;
    res.overflow = 1'b0;
    case (op)
      cpu_pkg::alu_or: res.value = a | b;
      cpu_pkg::alu_and: res.value = a & b;
      cpu_pkg::alu_eor: res.value = a ^ b;
      cpu_pkg::alu_add, cpu_pkg::alu_sub: begin
        res.value = sum[7:0];
        res.carry = sum[8];
        // same input signs but result sign flipped
        res.overflow = (a[7] == b_eff[7]) && (sum[7] != a[7]);
      end
      default: res.value = a;
    endcase
  end

endmodule

/* verilog/reg_file.sv */
//////////////////////////////////////////////////////////////////////
// A, X, Y and the N V Z C flags, with the ALU feeding writeback
// updates once per instruction, on the edge that ends execute
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_file (
  input logic CLK,
  input logic R,
  input cpu_pkg::decoded_t dec,
  input logic [7:0] operand,
  input logic wb_en,
  output logic [7:0] store_data,
  output cpu_pkg::p_flags_t flags
);

  logic [7:0] acc;
  logic [7:0] x_reg;
  logic [7:0] y_reg;
  logic [7:0] alu_a;
  logic [7:0] alu_b;
  logic cin;
  cpu_pkg::alu_result_t res;

  always_comb begin
    case (dec.src)
      cpu_pkg::reg_a: alu_a = acc;
      cpu_pkg::reg_x: alu_a = x_reg;
      cpu_pkg::reg_y: alu_a = y_reg;
      default: alu_a = 8'h00;
    endcase
    case (dec.cin)
      cpu_pkg::cin_one: cin = 1'b1;
      cpu_pkg::cin_flag: cin = flags.c;
      default: cin = 1'b0;
    endcase
    // implied ops see b = 0, counters rely on it
    alu_b = (dec.amode == cpu_pkg::am_implied) ? 8'h00 : operand;
  end

  assign store_data = alu_a;

  alu8 i_alu (
    .op(dec.op),
    .a(alu_a),
    .b(alu_b),
    .cin(cin),
    .res(res)
  );

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      acc <= 8'h00;
      x_reg <= 8'h00;
      y_reg <= 8'h00;
      flags <= '0;
    end else if (wb_en) begin
      case (dec.dst)
        cpu_pkg::reg_a: acc <= res.value;
        cpu_pkg::reg_x: x_reg <= res.value;
        cpu_pkg::reg_y: y_reg <= res.value;
        default: ;
      endcase
      if (dec.sets_nz) begin
        flags.n <= res.value[7];
        flags.z <= (res.value == 8'h00);
      end
      if (dec.sets_cv) begin
        flags.c <= res.carry;
        // compare leaves V alone
        if (dec.dst != cpu_pkg::reg_none)
          flags.v <= res.overflow;
      end
      if (dec.set_carry)
        flags.c <= 1'b1;
      if (dec.clear_carry)
        flags.c <= 1'b0;
    end
  end

  // sequencer only strobes writeback for instructions that change state
  assert property (@(posedge CLK) disable iff (R)
    wb_en |-> (dec.dst != cpu_pkg::reg_none) || dec.sets_nz ||
              dec.set_carry || dec.clear_carry);

endmodule

/* verilog/cpu_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// instruction sequencer and Wishbone classic master
// one bus cycle per state, advances on ack, one idle clock between
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_sequencer (
  input logic CLK,
  input logic R,
  input cpu_pkg::wb_s2m_t bus_in,
  input logic [7:0] store_data,
  output cpu_pkg::wb_m2s_t bus_out,
  output logic [7:0] opcode,
  output logic [7:0] operand,
  output logic wb_en,
  input cpu_pkg::decoded_t dec
);

  cpu_pkg::cpu_state_e state;
  cpu_pkg::cpu_state_e next_state;
  logic [15:0] pc;
  logic [7:0] opcode_q;
  logic cyc;
  logic done;

  assign done = cyc && bus_in.ack;

  // decoder already sees the new byte in the fetch ack cycle
  assign opcode = (state == cpu_pkg::st_fetch && done) ? bus_in.dat : opcode_q;

  assign wb_en = (state == cpu_pkg::st_execute) &&
                 ((dec.dst != cpu_pkg::reg_none) || dec.sets_nz ||
                  dec.set_carry || dec.clear_carry);

  always_comb begin
    bus_out.cyc = cyc;
    bus_out.stb = cyc;
    bus_out.we = (state == cpu_pkg::st_mem_write);
    bus_out.dat = (state == cpu_pkg::st_mem_write) ? store_data : 8'h00;
    if (state == cpu_pkg::st_mem_read || state == cpu_pkg::st_mem_write)
      bus_out.adr = {cpu_pkg::zero_page_hi, operand};
    else
      bus_out.adr = pc;
  end

  always_comb begin
    case (state)
      cpu_pkg::st_fetch:
        next_state = (dec.amode == cpu_pkg::am_implied) ? cpu_pkg::st_execute
                                                         : cpu_pkg::st_operand;
      cpu_pkg::st_operand: begin
        if (dec.is_jump)
          next_state = cpu_pkg::st_addr_hi;
        else if (dec.amode == cpu_pkg::am_immediate)
          next_state = cpu_pkg::st_execute;
        else if (dec.writes_mem)
          next_state = cpu_pkg::st_mem_write;
        else
          next_state = cpu_pkg::st_mem_read;
      end
      cpu_pkg::st_mem_read: next_state = cpu_pkg::st_execute;
      default: next_state = cpu_pkg::st_fetch;
    endcase
  end

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      state <= cpu_pkg::st_idle;
      cyc <= 1'b0;
      pc <= cpu_pkg::reset_pc;
    end else begin
      case (state)
        cpu_pkg::st_idle, cpu_pkg::st_execute: begin
          state <= next_state;
          cyc <= 1'b1;
        end
        default: begin
          if (!cyc) begin
            cyc <= 1'b1;
          end else if (bus_in.ack) begin
            cyc <= 1'b0;
            state <= next_state;
            if (state == cpu_pkg::st_fetch || state == cpu_pkg::st_operand)
              pc <= pc + 16'd1;
            else if (state == cpu_pkg::st_addr_hi)
              pc <= {bus_in.dat, operand};
          end
        end
      endcase
    end
  end

  // mem_read overwrites the zero-page address with the data byte
  always_ff @(posedge CLK) begin
    if (done && state == cpu_pkg::st_fetch)
      opcode_q <= bus_in.dat;
    if (done && (state == cpu_pkg::st_operand || state == cpu_pkg::st_mem_read))
      operand <= bus_in.dat;
  end

  // cycle ends in the clock after ack
  assert property (@(posedge CLK) disable iff (R)
    bus_out.stb && bus_in.ack |=> !bus_out.stb && !bus_out.cyc);

  assert property (@(posedge CLK) disable iff (R)
    bus_out.stb && !bus_in.ack |=> $stable({bus_out.adr, bus_out.we, bus_out.dat}));

endmodule

/* verilog/cpu_top.sv */
//////////////////////////////////////////////////////////////////////
// top of the accumulator core
// Wishbone classic master on bus_out/bus_in, flags on status
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_top (
  input logic CLK,
  input logic R,
  output cpu_pkg::wb_m2s_t bus_out,
  input cpu_pkg::wb_s2m_t bus_in,
  output cpu_pkg::p_flags_t status
);

  cpu_pkg::decoded_t dec;
  logic [7:0] opcode;
  logic [7:0] operand;
  logic [7:0] store_data;
  logic wb_en;

  cpu_sequencer i_seq (
    .CLK(CLK),
    .R(R),
    .bus_in(bus_in),
    .store_data(store_data),
    .bus_out(bus_out),
    .opcode(opcode),
    .operand(operand),
    .wb_en(wb_en),
    .dec(dec)
  );

  op_decoder i_dec (
    .opcode(opcode),
    .dec(dec)
  );

  reg_file i_regs (
    .CLK(CLK),
    .R(R),
    .dec(dec),
    .operand(operand),
    .wb_en(wb_en),
    .store_data(store_data),
    .flags(status)
  );

endmodule

/* tests/tb_memory.sv */
//////////////////////////////////////////////////////////////////////
// Wishbone classic slave memory for the core testbench
// 64 KiB, ack after a random number of wait cycles, loaded by tasks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_memory (
  input logic CLK,
  input logic R,
  input cpu_pkg::wb_m2s_t req,
  output cpu_pkg::wb_s2m_t rsp
);

  logic [7:0] mem [0:65535];
  int unsigned waits;

  // background that differs for every address
  task automatic fill_pattern();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'(i ^ (i >> 8)) ^ 8'hC3;
    end
  endtask

  task automatic write_byte(input logic [15:0] adr, input logic [7:0] dat);
    mem[adr] = dat;
  endtask

  always @(posedge CLK or posedge R) begin
    if (R) begin
      rsp <= '0;
      waits <= 0;
    end else begin
      rsp.ack <= 1'b0;
      // no new ack in the cycle that already carries one
      if (req.cyc && req.stb && !rsp.ack) begin
        if (waits == 0) begin
          rsp.ack <= 1'b1;
          if (req.we)
            mem[req.adr] = req.dat;
          else
            rsp.dat <= mem[req.adr];
          waits <= $urandom_range(2, 0);
        end else begin
          waits <= waits - 1;
        end
      end
    end
  end

endmodule

/* tests/tb_cpu.sv */
//////////////////////////////////////////////////////////////////////
// directed testbench for the accumulator core
// each test loads a short program at 0x0400, runs it to its final
// self jump and checks the stored bytes and the status flags
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cpu;

  // 17 runs of up to about 200 cycles, with margin
  localparam int cycle_limit = 4000;

  logic CLK;
  logic R;
  cpu_pkg::wb_m2s_t bus_out;
  cpu_pkg::wb_s2m_t bus_in;
  cpu_pkg::p_flags_t status;

  logic [7:0] prog[$];
  logic [15:0] loop_adr;
  logic loop_seen;
  logic first_seen;
  logic [15:0] first_adr;
  logic first_we;
  logic [15:0] rd_adr[$];
  logic [15:0] wr_adr[$];
  logic [7:0] wr_dat[$];
  int errors;
  int checks;
  int cycles;

  cpu_top i_dut (
    .CLK(CLK),
    .R(R),
    .bus_out(bus_out),
    .bus_in(bus_in),
    .status(status)
  );

  tb_memory i_mem (
    .CLK(CLK),
    .R(R),
    .req(bus_out),
    .rsp(bus_in)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: program did not reach its final loop within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  // records every completed bus cycle
  always @(posedge CLK) begin
    if (R) begin
      loop_seen <= 1'b0;
      first_seen = 1'b0;
      rd_adr.delete();
      wr_adr.delete();
      wr_dat.delete();
    end else if (bus_out.cyc && bus_out.stb && bus_in.ack) begin
      if (!first_seen) begin
        first_seen = 1'b1;
        first_adr = bus_out.adr;
        first_we = bus_out.we;
      end
      if (bus_out.we) begin
        wr_adr.push_back(bus_out.adr);
        wr_dat.push_back(bus_out.dat);
      end else begin
        rd_adr.push_back(bus_out.adr);
        if (bus_out.adr == loop_adr)
          loop_seen <= 1'b1;
      end
    end
  end

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flags(input cpu_pkg::p_flags_t got, input cpu_pkg::p_flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED status (nvzc): got %h, expected %h", got, exp);
    end
  endtask

  task automatic emit(input logic [7:0] b);
    prog.push_back(b);
  endtask

  task automatic emit2(input logic [7:0] op, input logic [7:0] arg);
    prog.push_back(op);
    prog.push_back(arg);
  endtask

  // final JMP onto itself
  task automatic emit_loop(input logic [15:0] base);
    logic [15:0] here;
    here = base + 16'(prog.size());
    loop_adr = here;
    emit(8'h4C);
    emit(here[7:0]);
    emit(here[15:8]);
  endtask

  task automatic load_at(input logic [15:0] base);
    foreach (prog[i])
      i_mem.write_byte(base + 16'(i), prog[i]);
    prog.delete();
  endtask

  task automatic begin_reset();
    @(posedge CLK);
    R <= 1'b1;
    @(posedge CLK);
    i_mem.fill_pattern();
    prog.delete();
  endtask

  task automatic release_and_wait();
    repeat (15) @(posedge CLK);
    R <= 1'b0;
    while (!loop_seen)
      @(posedge CLK);
  endtask

  task automatic expect_write(input int idx, input logic [7:0] adr, input logic [7:0] dat);
    if (idx >= wr_adr.size()) begin
      errors++;
      $display("bus write %0d to zero page %h never happened", idx, adr);
    end else begin
      check_addr("bus_out.adr", wr_adr[idx], {8'h00, adr});
      check_byte("bus_out.dat", wr_dat[idx], dat);
    end
  endtask

  task automatic expect_write_count(input int n);
    checks++;
    if (wr_adr.size() != n) begin
      errors++;
      $display("expected %0d bus writes but saw %0d", n, wr_adr.size());
    end
  endtask

  task automatic reset_first_fetch();
    begin_reset();
    check_byte("bus_out.cyc", {7'd0, bus_out.cyc}, 8'h00);
    emit2(8'hA2, 8'h11);
    emit(8'hE8);
    emit2(8'h86, 8'h08);
    emit_loop(16'h0400);
    load_at(16'h0400);
    release_and_wait();
    check_addr("first bus_out.adr", first_adr, 16'h0400);
    check_byte("first bus_out.we", {7'd0, first_we}, 8'h00);
    expect_write_count(1);
    expect_write(0, 8'h08, 8'h12);
    check_flags(status, 4'b0000);
  endtask

  task automatic loads_and_stores();
    logic [7:0] v[6];
    cpu_pkg::p_flags_t exp;
    foreach (v[i])
      v[i] = 8'($urandom);
    begin_reset();
    i_mem.write_byte(16'h0030, v[3]);
    i_mem.write_byte(16'h0031, v[4]);
    i_mem.write_byte(16'h0032, v[5]);
    emit2(8'hA9, v[0]);
    emit2(8'h85, 8'h40);
    emit2(8'hA2, v[1]);
    emit2(8'h86, 8'h41);
    emit2(8'hA0, v[2]);
    emit2(8'h84, 8'h42);
    emit2(8'hA5, 8'h30);
    emit2(8'h85, 8'h43);
    emit2(8'hA6, 8'h31);
    emit2(8'h86, 8'h44);
    emit2(8'hA4, 8'h32);
    emit2(8'h84, 8'h45);
    emit_loop(16'h0400);
    load_at(16'h0400);
    release_and_wait();
    expect_write_count(6);
    for (int i = 0; i < 6; i++)
      expect_write(i, 8'h40 + 8'(i), v[i]);
    exp = '0;
    exp.n = v[5][7];
    exp.z = (v[5] == 8'h00);
    check_flags(status, exp);
  endtask

  // one accumulator op on random operands with a chosen carry
  task automatic arith_case(input logic [7:0] op, input logic carry_in);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] r;
    int u;
    int s;
    int sa;
    int sb;
    cpu_pkg::p_flags_t exp;
    a = 8'($urandom);
    b = 8'($urandom);
    sa = $signed(a);
    sb = $signed(b);
    exp = '0;
    exp.c = carry_in;
    case (op)
      8'h09: r = a | b;
      8'h29: r = a & b;
      8'h49: r = a ^ b;
      8'h69: begin
        u = int'(a) + int'(b) + int'(carry_in);
        s = sa + sb + int'(carry_in);
        r = 8'(u);
        exp.c = (u > 255);
        exp.v = (s > 127) || (s < -128);
      end
      default: begin
        // borrow is the inverted carry
        u = int'(a) - int'(b) - (1 - int'(carry_in));
        s = sa - sb - (1 - int'(carry_in));
        r = 8'(u);
        exp.c = (u >= 0);
        exp.v = (s > 127) || (s < -128);
      end
    endcase
    exp.n = r[7];
    exp.z = (r == 8'h00);
    begin_reset();
    emit2(8'hA9, a);
    emit(carry_in ? 8'h38 : 8'h18);
    emit2(op, b);
    emit2(8'h85, 8'h10);
    emit_loop(16'h0400);
    load_at(16'h0400);
    release_and_wait();
    expect_write_count(1);
    expect_write(0, 8'h10, r);
    check_flags(status, exp);
  endtask

  task automatic logic_and_arith();
    logic [7:0] ops[5];
    ops = '{8'h09, 8'h29, 8'h49, 8'h69, 8'hE9};
    foreach (ops[i]) begin
      arith_case(ops[i], 1'b0);
      arith_case(ops[i], 1'b1);
    end
  endtask

  task automatic cmp_case(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] diff;
    cpu_pkg::p_flags_t exp;
    diff = a - b;
    exp = '0;
    exp.n = diff[7];
    exp.z = (a == b);
    exp.c = (a >= b);
    begin_reset();
    emit2(8'hA9, a);
    emit2(8'hC9, b);
    emit2(8'h85, 8'h20);
    emit_loop(16'h0400);
    load_at(16'h0400);
    release_and_wait();
    expect_write_count(1);
    expect_write(0, 8'h20, a);
    check_flags(status, exp);
  endtask

  task automatic compare_keeps_a();
    logic [7:0] a;
    a = 8'($urandom);
    cmp_case(8'($urandom), 8'($urandom));
    cmp_case(8'($urandom), 8'($urandom));
    cmp_case(a, a);
  endtask

  task automatic transfers_and_counters();
    begin_reset();
    emit2(8'hA9, 8'h5A);
    emit(8'hAA);
    emit(8'hE8);
    emit(8'h8A);
    emit2(8'h85, 8'h50);
    emit(8'hA8);
    emit(8'h88);
    emit(8'h88);
    emit(8'h98);
    emit2(8'h85, 8'h51);
    emit2(8'hA2, 8'h00);
    emit(8'hCA);
    emit2(8'h86, 8'h52);
    emit2(8'hA0, 8'hFF);
    emit(8'hC8);
    emit2(8'h84, 8'h53);
    emit_loop(16'h0400);
    load_at(16'h0400);
    release_and_wait();
    expect_write_count(4);
    expect_write(0, 8'h50, 8'h5B);
    expect_write(1, 8'h51, 8'h59);
    expect_write(2, 8'h52, 8'hFF);
    expect_write(3, 8'h53, 8'h00);
    // INY wrapped to zero last
    check_flags(status, 4'b0010);
  endtask

  task automatic jump_and_nop();
    int idx;
    begin_reset();
    emit(8'h4C);
    emit2(8'h80, 8'h04);
    load_at(16'h0400);
    // 0x02 is not a kept opcode
    emit(8'h02);
    emit2(8'hA9, 8'h97);
    emit2(8'h85, 8'h60);
    emit_loop(16'h0480);
    load_at(16'h0480);
    release_and_wait();
    idx = -1;
    foreach (rd_adr[i]) begin
      if (rd_adr[i] == 16'h0402 && idx < 0)
        idx = i;
    end
    if (idx < 0 || idx + 1 >= rd_adr.size()) begin
      errors++;
      $display("no fetch after the JMP high byte was seen");
    end else begin
      check_addr("fetch after JMP", rd_adr[idx + 1], 16'h0480);
    end
    expect_write_count(1);
    expect_write(0, 8'h60, 8'h97);
    check_flags(status, 4'b1000);
  endtask

  initial begin
    R <= 1'b1;
    loop_adr = 16'hFFFF;
    first_seen = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    void'($urandom(32'ha555c998));
    reset_first_fetch();
    loads_and_stores();
    logic_and_arith();
    compare_keeps_a();
    transfers_and_counters();
    jump_and_nop();
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* flist.f */
verilog/cpu_pkg.sv
verilog/op_decoder.sv
verilog/alu8.sv
verilog/reg_file.sv
verilog/cpu_sequencer.sv
verilog/cpu_top.sv
tests/tb_memory.sv
tests/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator, result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_cpu -o tb_cpu_sim \
  && ./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
